/* corr_top.f */
hw/corr_pkg.sv
hw/rst_sync.sv
hw/sync_bit.sv
hw/corr_regs.sv
hw/corr_engine.sv
hw/corr_pwm.sv
hw/corr_top.sv
test/tb_corr_top.sv

/* hw/corr_engine.sv */
module corr_engine import corr_pkg::*; (
  input  logic      i_clk,
  input  logic      i_arst_n,
  input  probe_t    i_probe,
  input  corr_cfg_t i_cfg,
  output corr_sts_t o_sts
);

  probe_t           agree;     // masked bits equal to pattern
  probe_t           miss;      // masked bits that differ
  logic [CNT_W-1:0] cnt_d;
  logic             full_d;
  logic             full_rise;
  logic [CNT_W-1:0] cnt_q;
  logic             full_q;
  logic [HIT_W-1:0] hits_q;

  assign agree = ~(i_probe ^ i_cfg.pattern) & i_cfg.mask;
  assign miss  = (i_probe ^ i_cfg.pattern) & i_cfg.mask;

  // population count of agreeing bits
  always_comb begin
    cnt_d = '0;
    for (int i = 0; i < N_PROBE; i++) begin
      cnt_d = cnt_d + CNT_W'(agree[i]);
    end
  end

  // an empty mask counts as a full match
  assign full_d    = i_cfg.enable && (miss == '0);
  assign full_rise = full_d && !full_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      cnt_q  <= '0;
      full_q <= 1'b0;
    end else begin
      cnt_q  <= i_cfg.enable ? cnt_d : '0;
      full_q <= full_d;
    end
  end

  // hits hold while disabled since full_d stays low
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hits_q <= '0;
    end else if (i_cfg.hit_clr) begin
      hits_q <= '0;  // clear beats increment
    end else if (full_rise && (hits_q != '1)) begin
      hits_q <= hits_q + 1'b1;
    end
  end

  assign o_sts.match_cnt = cnt_q;
  assign o_sts.full      = full_q;
  assign o_sts.hits      = hits_q;

endmodule

/* hw/corr_pkg.sv */
package corr_pkg;

  // probe and counter widths
  localparam int N_PROBE = 16;
  localparam int CNT_W   = 5;  // 0..16 matching bits
  localparam int HIT_W   = 16;

  // register port
  localparam int WB_AW = 3;  // word address
  localparam int WB_DW = 32;

  // pwm
  localparam int PWM_PERIOD = 16;
  localparam int PWM_CW     = $clog2(PWM_PERIOD);

  // input conditioning
  localparam int N_SYNC         = 2;
  localparam int PROBE_DEBOUNCE = 4;
  localparam int BTN_DEBOUNCE   = 8;

  localparam logic [WB_DW-1:0] CORR_VERSION = 32'h0001_0003;

  // register map, word addresses
  localparam logic [WB_AW-1:0] ADDR_CTRL    = 3'd0;
  localparam logic [WB_AW-1:0] ADDR_PATTERN = 3'd1;
  localparam logic [WB_AW-1:0] ADDR_MASK    = 3'd2;
  localparam logic [WB_AW-1:0] ADDR_STATUS  = 3'd3;
  localparam logic [WB_AW-1:0] ADDR_HITS    = 3'd4;  // write clears
  localparam logic [WB_AW-1:0] ADDR_BTN     = 3'd5;  // write clears
  localparam logic [WB_AW-1:0] ADDR_VERSION = 3'd6;

  // bit position of the full flag in STATUS
  localparam int STS_FULL_BIT = 8;

  typedef logic [N_PROBE-1:0] probe_t;

  // configuration from the register bank to the engine
  typedef struct packed {
    logic   enable;
    probe_t pattern;
    probe_t mask;
    logic   hit_clr;  // one clock pulse
  } corr_cfg_t;

  // status from the engine
  typedef struct packed {
    logic [CNT_W-1:0] match_cnt;
    logic             full;
    logic [HIT_W-1:0] hits;
  } corr_sts_t;

endpackage

/* hw/corr_pwm.sv */
module corr_pwm import corr_pkg::*; (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic [CNT_W-1:0] i_duty,
  output logic             o_pwm
);

  logic [PWM_CW-1:0] period_q;
  logic [CNT_W-1:0]  duty_q;
  logic              wrap;

  assign wrap = (period_q == PWM_CW'(PWM_PERIOD - 1));

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      period_q <= '0;
      duty_q   <= '0;
    end else begin
      if (wrap) begin
        period_q <= '0;
        duty_q   <= i_duty;  // only changes at period boundary
      end else begin
        period_q <= period_q + 1'b1;
      end
    end
  end

  // duty of PWM_PERIOD keeps it high
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_pwm <= 1'b0;
    end else begin
      o_pwm <= (CNT_W'(period_q) < duty_q);
    end
  end

endmodule

/* hw/corr_regs.sv */
module corr_regs import corr_pkg::*; (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_wb_cyc,
  input  logic             i_wb_stb,
  input  logic             i_wb_we,
  input  logic [WB_AW-1:0] i_wb_adr,
  input  logic [WB_DW-1:0] i_wb_dat,
  input  logic             i_btn_rise,
  input  corr_sts_t        i_sts,
  output logic [WB_DW-1:0] o_wb_dat,
  output logic             o_wb_ack,
  output corr_cfg_t        o_cfg
);

  logic             req;
  logic             wr;
  logic             enable_q;
  probe_t           pattern_q;
  probe_t           mask_q;
  logic             hit_clr_q;
  logic [HIT_W-1:0] btn_cnt_q;
  logic [WB_DW-1:0] rd_data;

  // new request, not the one being acked
  assign req = i_wb_cyc && i_wb_stb && !o_wb_ack;
  assign wr  = req && i_wb_we;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_ack  <= 1'b0;
      enable_q  <= 1'b0;
      pattern_q <= '0;
      mask_q    <= '0;
      hit_clr_q <= 1'b0;
    end else begin
      o_wb_ack  <= req;
      hit_clr_q <= wr && (i_wb_adr == ADDR_HITS);  // any data clears
      if (wr) begin
        case (i_wb_adr)
          ADDR_CTRL:    enable_q  <= i_wb_dat[0];
          ADDR_PATTERN: pattern_q <= i_wb_dat[N_PROBE-1:0];
          ADDR_MASK:    mask_q    <= i_wb_dat[N_PROBE-1:0];
          default:      ;  // read only or unmapped
        endcase
      end
    end
  end

  // button presses, clear wins over a press
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      btn_cnt_q <= '0;
    end else if (wr && (i_wb_adr == ADDR_BTN)) begin
      btn_cnt_q <= '0;
    end else if (i_btn_rise && (btn_cnt_q != '1)) begin
      btn_cnt_q <= btn_cnt_q + 1'b1;
    end
  end

  always_comb begin
    rd_data = '0;
    case (i_wb_adr)
      ADDR_CTRL:    rd_data[0]         = enable_q;
      ADDR_PATTERN: rd_data[N_PROBE-1:0] = pattern_q;
      ADDR_MASK:    rd_data[N_PROBE-1:0] = mask_q;
      ADDR_STATUS: begin
        rd_data[CNT_W-1:0]   = i_sts.match_cnt;
        rd_data[STS_FULL_BIT] = i_sts.full;
      end
      ADDR_HITS:    rd_data = WB_DW'(i_sts.hits);
      ADDR_BTN:     rd_data = WB_DW'(btn_cnt_q);
      ADDR_VERSION: rd_data = CORR_VERSION;
      default:      rd_data = '0;  // unmapped reads zero
    endcase
  end

  // valid together with ack
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_wb_dat <= '0;
    end else if (req) begin
      o_wb_dat <= rd_data;
    end else begin
      o_wb_dat <= '0;
    end
  end

  assign o_cfg.enable  = enable_q;
  assign o_cfg.pattern = pattern_q;
  assign o_cfg.mask    = mask_q;
  assign o_cfg.hit_clr = hit_clr_q;

endmodule

/* hw/corr_top.sv */
module corr_top import corr_pkg::*; (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_wb_cyc,
  input  logic             i_wb_stb,
  input  logic             i_wb_we,
  input  logic [WB_AW-1:0] i_wb_adr,
  input  logic [WB_DW-1:0] i_wb_dat,
  output logic [WB_DW-1:0] o_wb_dat,
  output logic             o_wb_ack,
  input  probe_t           i_probe,
  input  logic             i_btn,
  output logic             o_pwm,
  output logic             o_en,
  output logic             o_btn
);

  logic      rst_n;
  probe_t    probe_q;
  logic      btn_rise;
  corr_cfg_t cfg;
  corr_sts_t sts;

  rst_sync u_rst_sync (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .o_rst_n  (rst_n)
  );

  sync_bit #(
    .T_BITS          (probe_t),
    .DEBOUNCE_CYCLES (PROBE_DEBOUNCE)
  ) u_probe_sync (
    .i_clk    (i_clk),
    .i_arst_n (rst_n),
    .i_bits   (i_probe),
    .o_bits   (probe_q),
    .o_rise   (),  // edges not needed on probes
    .o_fall   ()
  );

  sync_bit #(
    .T_BITS          (logic),
    .DEBOUNCE_CYCLES (BTN_DEBOUNCE)
  ) u_btn_sync (
    .i_clk    (i_clk),
    .i_arst_n (rst_n),
    .i_bits   (i_btn),
    .o_bits   (o_btn),     // level LED
    .o_rise   (btn_rise),  // press counter
    .o_fall   ()
  );

  corr_regs u_corr_regs (
    .i_clk      (i_clk),
    .i_arst_n   (rst_n),
    .i_wb_cyc   (i_wb_cyc),
    .i_wb_stb   (i_wb_stb),
    .i_wb_we    (i_wb_we),
    .i_wb_adr   (i_wb_adr),
    .i_wb_dat   (i_wb_dat),
    .i_btn_rise (btn_rise),
    .i_sts      (sts),
    .o_wb_dat   (o_wb_dat),
    .o_wb_ack   (o_wb_ack),
    .o_cfg      (cfg)
  );

  corr_engine u_corr_engine (
    .i_clk    (i_clk),
    .i_arst_n (rst_n),
    .i_probe  (probe_q),
    .i_cfg    (cfg),
    .o_sts    (sts)
  );

  corr_pwm u_corr_pwm (
    .i_clk    (i_clk),
    .i_arst_n (rst_n),
    .i_duty   (sts.match_cnt),
    .o_pwm    (o_pwm)
  );

  assign o_en = cfg.enable;  // enable LED

endmodule

/* hw/rst_sync.sv */
module rst_sync (
  input  logic i_clk,
  input  logic i_arst_n,
  output logic o_rst_n
);

  logic [1:0] sync_q;

  // assert at once, release after two edges
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[0], 1'b1};  // shift ones in
    end
  end

  assign o_rst_n = sync_q[1];

endmodule

/* hw/sync_bit.sv */
module sync_bit import corr_pkg::*; #(
  parameter type T_BITS          = logic,
  parameter int  DEBOUNCE_CYCLES = 4
) (
  input  logic  i_clk,
  input  logic  i_arst_n,
  input  T_BITS i_bits,
  output T_BITS o_bits,
  output T_BITS o_rise,
  output T_BITS o_fall
);

  localparam int DB_W = $clog2(DEBOUNCE_CYCLES + 1);

  T_BITS           sync_q [N_SYNC];  // metastability chain
  T_BITS           prev_q;           // last synchronized value
  T_BITS           sync_last;
  logic [DB_W-1:0] stable_q;         // clocks without change
  logic            load;

  assign sync_last = sync_q[N_SYNC-1];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 0; i < N_SYNC; i++) begin
        sync_q[i] <= '0;
      end
    end else begin
      sync_q[0] <= i_bits;
      for (int i = 1; i < N_SYNC; i++) begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // any change restarts the count
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      prev_q   <= '0;
      stable_q <= '0;
    end else begin
      prev_q <= sync_last;
      if (sync_last != prev_q) begin
        stable_q <= '0;
      end else if (stable_q != DB_W'(DEBOUNCE_CYCLES)) begin
        stable_q <= stable_q + 1'b1;  // saturates
      end
    end
  end

  // fires once per stable period
  assign load = (sync_last == prev_q) && (stable_q == DB_W'(DEBOUNCE_CYCLES - 1));

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_bits <= '0;
      o_rise <= '0;
      o_fall <= '0;
    end else if (load) begin
      o_bits <= prev_q;
      o_rise <= prev_q & ~o_bits;   // per bit 0 -> 1
      o_fall <= ~prev_q & o_bits;   // per bit 1 -> 0
    end else begin
      o_rise <= '0;
      o_fall <= '0;
    end
  end

endmodule

/* test/tb_corr_top.sv */
module tb_corr_top import corr_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int SETTLE     = 20;    // sync + debounce + engine latency with margin
  localparam int ACK_LIMIT  = 50;
  localparam int MAX_CYCLES = 4000;
  localparam logic [31:0] SEED = 32'had20_44be;

  logic             i_clk;
  logic             i_arst_n;
  logic             i_wb_cyc;
  logic             i_wb_stb;
  logic             i_wb_we;
  logic [WB_AW-1:0] i_wb_adr;
  logic [WB_DW-1:0] i_wb_dat;
  logic [WB_DW-1:0] o_wb_dat;
  logic             o_wb_ack;
  probe_t           i_probe;
  logic             i_btn;
  logic             o_pwm;
  logic             o_en;
  logic             o_btn;

  int errors = 0;
  int cycles = 0;

  corr_top dut (.*);

  initial begin
    i_clk = 1'b0;
    forever #4 i_clk = ~i_clk;  // 8 ns period
  end

  // run limit
  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= MAX_CYCLES) begin
      $display("run did not finish within %0d cycles", MAX_CYCLES);
      $display("Something failed");
      $finish;
    end
  end

  task automatic wait_clocks(input int n);
    repeat (n) begin
      @(posedge i_clk);
      #1;  // drive and sample just after the edge
    end
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  // one classic cycle, returns the read data
  task automatic wb_access(input logic we, input logic [WB_AW-1:0] adr,
                           input logic [WB_DW-1:0] wdat, output logic [WB_DW-1:0] rdat);
    int n;
    n = 0;
    i_wb_cyc = 1'b1;
    i_wb_stb = 1'b1;
    i_wb_we  = we;
    i_wb_adr = adr;
    i_wb_dat = wdat;
    do begin
      wait_clocks(1);
      n++;
    end while (!o_wb_ack && n < ACK_LIMIT);
    if (!o_wb_ack) begin
      $display("no acknowledge from register port at %0t", $time);
      errors++;
    end else begin
      check("o_wb_ack latency", n, 1);  // registered ack
    end
    rdat     = o_wb_dat;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    wait_clocks(1);  // let ack fall
    check("o_wb_ack", o_wb_ack, 0);  // one clock only
  endtask

  task automatic wb_write(input logic [WB_AW-1:0] adr, input logic [WB_DW-1:0] wdat);
    logic [WB_DW-1:0] unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read(input logic [WB_AW-1:0] adr, output logic [WB_DW-1:0] rdat);
    wb_access(1'b0, adr, '0, rdat);
  endtask

  task automatic read_expect(input string name, input logic [WB_AW-1:0] adr,
                             input logic [31:0] exp);
    logic [WB_DW-1:0] rdat;
    wb_read(adr, rdat);
    check(name, rdat, exp);
  endtask

  task automatic set_probe(input probe_t value);
    i_probe = value;
    wait_clocks(SETTLE);
  endtask

  task automatic press_btn(input logic level);
    i_btn = level;
    wait_clocks(SETTLE);
  endtask

  // masked bits where probe equals pattern
  function automatic int count_agree(input probe_t p, input probe_t pat, input probe_t msk);
    int n;
    n = 0;
    for (int i = 0; i < N_PROBE; i++) begin
      if (msk[i] && (p[i] == pat[i])) n++;
    end
    return n;
  endfunction

  function automatic logic [31:0] status_word(input probe_t p, input probe_t pat,
                                              input probe_t msk);
    logic [31:0] w;
    w    = 32'(count_agree(p, pat, msk));
    w[8] = 1'b1;  // full unless a masked bit differs
    for (int i = 0; i < N_PROBE; i++) begin
      if (msk[i] && (p[i] != pat[i])) w[8] = 1'b0;
    end
    return w;
  endfunction

  task automatic reset_and_version();
    check("o_pwm", o_pwm, 0);
    check("o_en", o_en, 0);
    check("o_btn", o_btn, 0);
    check("o_wb_ack", o_wb_ack, 0);
    read_expect("CTRL", ADDR_CTRL, 0);
    read_expect("PATTERN", ADDR_PATTERN, 0);
    read_expect("MASK", ADDR_MASK, 0);
    read_expect("VERSION", ADDR_VERSION, CORR_VERSION);
  endtask

  task automatic register_readback();
    logic [31:0] pat;
    logic [31:0] msk;
    pat = $urandom;
    msk = $urandom;
    wb_write(ADDR_PATTERN, pat);
    wb_write(ADDR_MASK, msk);
    read_expect("PATTERN", ADDR_PATTERN, pat & 32'h0000_ffff);  // 16 bits kept
    read_expect("MASK", ADDR_MASK, msk & 32'h0000_ffff);
    wb_write(3'd7, $urandom);
    read_expect("unmapped", 3'd7, 0);
    read_expect("CTRL", ADDR_CTRL, 0);
    read_expect("PATTERN", ADDR_PATTERN, pat & 32'h0000_ffff);
    read_expect("MASK", ADDR_MASK, msk & 32'h0000_ffff);
    wb_write(ADDR_CTRL, 32'h1);
    check("o_en", o_en, 1);
    read_expect("CTRL", ADDR_CTRL, 1);
  endtask

  task automatic match_count_sweep();
    probe_t pat;
    probe_t msk;
    probe_t p;
    for (int k = 0; k < 10; k++) begin
      pat = probe_t'($urandom);
      msk = probe_t'($urandom);
      p   = probe_t'($urandom);
      if (k == 9) p = pat;  // at least one full match
      wb_write(ADDR_PATTERN, 32'(pat));
      wb_write(ADDR_MASK, 32'(msk));
      set_probe(p);
      read_expect("STATUS", ADDR_STATUS, status_word(p, pat, msk));
    end
    wb_write(ADDR_CTRL, 32'h0);
    wait_clocks(2);
    read_expect("STATUS disabled", ADDR_STATUS, 0);
    wb_write(ADDR_CTRL, 32'h1);
  endtask

  task automatic pwm_case(input probe_t p, input probe_t pat, input probe_t msk);
    int high;
    high = 0;
    wb_write(ADDR_PATTERN, 32'(pat));
    wb_write(ADDR_MASK, 32'(msk));
    set_probe(p);
    wait_clocks(PWM_PERIOD + 2);  // new duty latched at wrap
    for (int i = 0; i < PWM_PERIOD; i++) begin
      if (o_pwm) high++;
      wait_clocks(1);
    end
    check("o_pwm high clocks", high, count_agree(p, pat, msk));
  endtask

  task automatic pwm_duty();
    probe_t pat;
    pat = probe_t'($urandom);
    pwm_case(pat, pat, 16'hffff);   // duty 16
    pwm_case(pat, pat, 16'h0000);   // duty 0
    pwm_case(~pat, pat, 16'hffff);
    for (int k = 0; k < 3; k++) begin
      pwm_case(probe_t'($urandom), probe_t'($urandom), probe_t'($urandom));
    end
  endtask

  task automatic hits_and_debounce();
    probe_t pat;
    probe_t msk;
    probe_t miss;
    pat  = probe_t'($urandom);
    msk  = probe_t'($urandom) | 16'h0001;
    miss = pat ^ 16'h0001;  // bit 0 is always masked
    wb_write(ADDR_PATTERN, 32'(pat));
    wb_write(ADDR_MASK, 32'(msk));
    set_probe(miss);
    wb_write(ADDR_HITS, $urandom);
    read_expect("HITS cleared", ADDR_HITS, 0);
    for (int k = 0; k < 4; k++) begin
      set_probe(pat);
      set_probe(miss);
    end
    read_expect("HITS", ADDR_HITS, 4);
    i_probe = pat;  // too short to pass the debouncer
    wait_clocks(PROBE_DEBOUNCE - 2);
    set_probe(miss);
    read_expect("HITS after glitch", ADDR_HITS, 4);
    read_expect("STATUS after glitch", ADDR_STATUS, status_word(miss, pat, msk));
    wb_write(ADDR_HITS, 32'h0);
    read_expect("HITS cleared", ADDR_HITS, 0);
  endtask

  task automatic button_presses();
    wb_write(ADDR_BTN, 32'h0);
    for (int k = 0; k < 3; k++) begin
      press_btn(1'b1);
      check("o_btn", o_btn, 1);
      press_btn(1'b0);
      check("o_btn", o_btn, 0);
    end
    read_expect("BTN", ADDR_BTN, 3);
    i_btn = 1'b1;  // bounce
    wait_clocks(BTN_DEBOUNCE - 3);
    press_btn(1'b0);
    check("o_btn after bounce", o_btn, 0);
    read_expect("BTN after bounce", ADDR_BTN, 3);
    wb_write(ADDR_BTN, $urandom);
    read_expect("BTN cleared", ADDR_BTN, 0);
  endtask

  initial begin
    void'($urandom(SEED));
    i_arst_n = 1'b0;
    i_wb_cyc = 1'b0;
    i_wb_stb = 1'b0;
    i_wb_we  = 1'b0;
    i_wb_adr = '0;
    i_wb_dat = '0;
    i_probe  = '0;
    i_btn    = 1'b0;
    repeat (5) @(posedge i_clk);
    #1 i_arst_n = 1'b1;
    wait_clocks(3);  // synchronous release
    reset_and_version();
    register_readback();
    match_count_sweep();
    pwm_duty();
    hits_and_debounce();
    button_presses();
    $display("%0d errors after %0d cycles", errors, cycles);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule
